//--- all.f
hw/serial_slave_pkg.sv
hw/bit_deserializer.sv
hw/word_serializer.sv
hw/slave_mem.sv
hw/slave_ctrl.sv
hw/serial_slave.sv
tests/serial_slave_assert.sv
tests/tb_serial_slave.sv

//--- hw/bit_deserializer.sv
`timescale 1ns/1ps

module bit_deserializer #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rstN,
    input  logic     shift_en,
    input  logic     din,
    output payload_t data,
    output logic     done
);

    localparam int WIDTH     = $bits(payload_t);
    localparam int CNT_WIDTH = $clog2(WIDTH);

    logic [WIDTH-1:0]     shreg;
    logic [CNT_WIDTH-1:0] cnt;

    // msb arrives first, so every new bit enters at the lsb
    always_ff @(posedge clk) begin
        if (shift_en) begin
            shreg <= {shreg[WIDTH-2:0], din};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cnt <= '0;
        end else if (shift_en) begin
            if (done) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // high while the final bit is being sampled
    assign done = shift_en && (cnt == CNT_WIDTH'(WIDTH - 1));

    assign data = payload_t'(shreg);

endmodule

//--- hw/serial_slave.sv
`timescale 1ns/1ps

module serial_slave
    import serial_slave_pkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wD,
    input  logic valid,
    input  logic last,
    output logic rD,
    output logic ready
);

    dp_cmd_t     cmd;
    ctrl_frame_t frame;
    data_t       wr_word;
    data_t       rd_word;
    logic        frame_done;
    logic        word_done;
    logic        ser_done;

    slave_ctrl u_ctrl (
        .clk        (clk),
        .rstN       (rstN),
        .control    (control),
        .valid      (valid),
        .last       (last),
        .frame      (frame),
        .frame_done (frame_done),
        .word_done  (word_done),
        .ser_done   (ser_done),
        .cmd        (cmd),
        .ready      (ready)
    );

    // control line into the frame register
    bit_deserializer #(
        .payload_t (ctrl_frame_t)
    ) u_frame_deser (
        .clk      (clk),
        .rstN     (rstN),
        .shift_en (cmd.frame_capture),
        .din      (control),
        .data     (frame),
        .done     (frame_done)
    );

    // wD into the write word
    bit_deserializer #(
        .payload_t (data_t)
    ) u_word_deser (
        .clk      (clk),
        .rstN     (rstN),
        .shift_en (cmd.word_capture),
        .din      (wD),
        .data     (wr_word),
        .done     (word_done)
    );

    slave_mem u_mem (
        .clk   (clk),
        .we    (cmd.mem_write),
        .re    (cmd.mem_read),
        .addr  (cmd.mem_addr),
        .wdata (wr_word),
        .rdata (rd_word)
    );

    word_serializer u_ser (
        .clk     (clk),
        .rstN    (rstN),
        .load    (cmd.ser_load),
        .shift   (cmd.ser_shift),
        .word    (rd_word),
        .bit_out (rD),
        .done    (ser_done)
    );

endmodule

//--- hw/serial_slave_pkg.sv
package serial_slave_pkg;

    // memory geometry
    localparam int MEM_DEPTH      = 2000;
    localparam int ADDR_WIDTH     = 11;
    localparam int DATA_WIDTH     = 32;
    localparam int DATA_CNT_WIDTH = $clog2(DATA_WIDTH);

    // control frame layout
    localparam int SID_WIDTH   = 2;
    localparam int START_WIDTH = 3;
    localparam int FRAME_WIDTH = START_WIDTH + SID_WIDTH + 2 + ADDR_WIDTH;

    localparam logic [SID_WIDTH-1:0]   SLAVE_ID      = 2'd1;
    localparam logic [START_WIDTH-1:0] START_PATTERN = 3'b111;

    // idle cycles ahead of every memory read
    localparam int ACCESS_DELAY = 2;
    localparam int DELAY_WIDTH  = $clog2(ACCESS_DELAY + 1);

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // first field is the first bit on the control line
    typedef struct packed {
        logic [START_WIDTH-1:0] start;
        logic [SID_WIDTH-1:0]   sid;
        logic                   write;
        logic                   burst;
        addr_t                  addr;
    } ctrl_frame_t;

    // strobes from the FSM to the datapath
    typedef struct packed {
        logic  frame_capture;
        logic  word_capture;
        logic  mem_write;
        logic  mem_read;
        logic  ser_load;
        logic  ser_shift;
        addr_t mem_addr;
    } dp_cmd_t;

endpackage

//--- hw/slave_ctrl.sv
`timescale 1ns/1ps

module slave_ctrl
    import serial_slave_pkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        control,
    input  logic        valid,
    input  logic        last,
    input  ctrl_frame_t frame,
    input  logic        frame_done,
    input  logic        word_done,
    input  logic        ser_done,
    output dp_cmd_t     cmd,
    output logic        ready
);

    localparam logic [DELAY_WIDTH-1:0] DELAY_LAST = DELAY_WIDTH'(ACCESS_DELAY - 1);

    typedef enum logic [2:0] {
        st_idle,
        st_frame,
        st_decode,
        st_write,
        st_write_store,
        st_read_wait,
        st_read_load,
        st_read_shift
    } state_t;

    state_t                 state;
    state_t                 state_nxt;
    addr_t                  addr_q;
    logic [DELAY_WIDTH-1:0] delay_cnt;
    logic                   is_burst;
    logic                   last_seen;
    logic                   frame_ok;
    logic                   wr_more;
    logic                   rd_more;

    assign frame_ok = (frame.start == START_PATTERN) && (frame.sid == SLAVE_ID);

    // burst goes on unless last was seen during the word just finished
    assign wr_more = is_burst && !last_seen;
    assign rd_more = is_burst && !last_seen && !last;

    always_comb begin
        state_nxt    = state;
        cmd          = '0;
        cmd.mem_addr = addr_q;
        ready        = 1'b1;
        case (state)
            st_idle: begin
                // first high bit is already frame bit 17
                cmd.frame_capture = control;
                if (control) begin
                    state_nxt = st_frame;
                end
            end
            st_frame: begin
                cmd.frame_capture = 1'b1;
                if (frame_done) begin
                    state_nxt = st_decode;
                end
            end
            st_decode: begin
                ready = 1'b0;
                if (!frame_ok) begin
                    state_nxt = st_idle;
                end else if (frame.write) begin
                    state_nxt = st_write;
                end else begin
                    state_nxt = st_read_wait;
                end
            end
            st_write: begin
                // valid low simply stalls the word
                cmd.word_capture = valid;
                if (word_done) begin
                    state_nxt = st_write_store;
                end
            end
            st_write_store: begin
                cmd.mem_write = 1'b1;
                state_nxt     = wr_more ? st_write : st_idle;
            end
            st_read_wait: begin
                ready = 1'b0;
                // array read overlaps the last delay cycle
                if (delay_cnt == DELAY_LAST) begin
                    cmd.mem_read = 1'b1;
                    state_nxt    = st_read_load;
                end
            end
            st_read_load: begin
                ready        = 1'b0;
                cmd.ser_load = 1'b1;
                state_nxt    = st_read_shift;
            end
            st_read_shift: begin
                cmd.ser_shift = 1'b1;
                if (ser_done) begin
                    state_nxt = rd_more ? st_read_wait : st_idle;
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= st_idle;
            addr_q    <= '0;
            delay_cnt <= '0;
            is_burst  <= 1'b0;
            last_seen <= 1'b0;
        end else begin
            state <= state_nxt;

            if (state == st_read_wait && state_nxt == st_read_wait) begin
                delay_cnt <= delay_cnt + 1'b1;
            end else begin
                delay_cnt <= '0;
            end

            case (state)
                st_decode: begin
                    addr_q    <= frame.addr;
                    is_burst  <= frame.burst;
                    last_seen <= 1'b0;
                end
                st_write: begin
                    if (last) begin
                        last_seen <= 1'b1;
                    end
                end
                st_write_store: begin
                    last_seen <= 1'b0;
                    if (wr_more) begin
                        addr_q <= addr_q + 1'b1;
                    end
                end
                st_read_shift: begin
                    if (ser_done) begin
                        last_seen <= 1'b0;
                        if (rd_more) begin
                            addr_q <= addr_q + 1'b1;
                        end
                    end else if (last) begin
                        last_seen <= 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- hw/slave_mem.sv
`timescale 1ns/1ps

module slave_mem
    import serial_slave_pkg::*;
(
    input  logic  clk,
    input  logic  we,
    input  logic  re,
    input  addr_t addr,
    input  data_t wdata,
    output data_t rdata
);

    // contents stay undefined until written
    data_t mem [0:MEM_DEPTH-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // read data shows up one cycle after re
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[addr];
        end
    end

endmodule

//--- hw/word_serializer.sv
`timescale 1ns/1ps

module word_serializer
    import serial_slave_pkg::*;
(
    input  logic  clk,
    input  logic  rstN,
    input  logic  load,
    input  logic  shift,
    input  data_t word,
    output logic  bit_out,
    output logic  done
);

    data_t                     shreg;
    logic [DATA_CNT_WIDTH-1:0] cnt;
    logic                      full;

    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= word;
        end else if (shift) begin
            shreg <= {shreg[DATA_WIDTH-2:0], 1'b0};
        end
    end

    // full marks a word that still has bits to send
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cnt  <= '0;
            full <= 1'b0;
        end else if (load) begin
            cnt  <= '0;
            full <= 1'b1;
        end else if (shift && full) begin
            if (done) begin
                cnt  <= '0;
                full <= 1'b0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // asserted in the cycle that carries bit 0
    assign done = shift && full && (cnt == DATA_CNT_WIDTH'(DATA_WIDTH - 1));

    // line idles low between words
    assign bit_out = full & shreg[DATA_WIDTH-1];

endmodule

//--- run.sh
#!/usr/bin/env bash
# builds the serial slave testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_serial_slave \
    -o tb_serial_slave || { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/tb_serial_slave)
echo "$sim_out"
grep -qF "All tests passed!" <<< "$sim_out" && exit 0 || exit 1

//--- tests/serial_slave_assert.sv
`timescale 1ns/1ps

module serial_slave_assert
    import serial_slave_pkg::*;
(
    input logic    clk,
    input logic    rstN,
    input logic    ready,
    input dp_cmd_t cmd
);

    // single port, so a write and a read never share a cycle
    a_no_rw_overlap: assert property (@(posedge clk) disable iff (!rstN)
        !(cmd.mem_write && cmd.mem_read))
        else $error("mem_write and mem_read are high in the same cycle");

    // the FSM comes out of reset in idle with ready high
    a_ready_after_reset: assert property (@(posedge clk) $rose(rstN) |-> ready)
        else $error("ready is low in the first cycle after reset release");

    a_addr_in_range: assert property (@(posedge clk) disable iff (!rstN)
        (cmd.mem_write || cmd.mem_read) |-> (int'(cmd.mem_addr) < MEM_DEPTH))
        else $error("memory access with an address beyond the last word");

endmodule

bind slave_ctrl serial_slave_assert u_ctrl_assert (
    .clk   (clk),
    .rstN  (rstN),
    .ready (ready),
    .cmd   (cmd)
);

//--- tests/tb_serial_slave.sv
`timescale 1ns/1ps

module tb_serial_slave
    import serial_slave_pkg::*;
();

    localparam int HALF_PERIOD = 4;
    localparam int DRIVE_DELAY = 1;
    localparam int TIMEOUT     = 200;
    localparam int SEED        = 92;

    logic clk;
    logic rstN;
    logic control;
    logic wD;
    logic valid;
    logic last;
    logic rD;
    logic ready;

    // expected memory contents, updated on every accepted write
    data_t ref_mem [MEM_DEPTH];

    int errors;
    int checks;
    int tests_run;
    bit timed_out;

    serial_slave i_serial_slave (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .wD      (wD),
        .valid   (valid),
        .last    (last),
        .rD      (rD),
        .ready   (ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("error: %s = %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string msg);
        checks++;
        assert (cond) else begin
            $display("%s", msg);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        errors++;
        timed_out = 1'b1;
    endtask

    task automatic log_test_end(input string name, input int errors_before);
        tests_run++;
        $display("test %s finished with %0d errors", name, errors - errors_before);
    endtask

    // shifts the frame out on control, msb first, no gaps
    task automatic send_frame(input logic [START_WIDTH-1:0] start,
                              input logic [SID_WIDTH-1:0] sid, input logic wr,
                              input logic burst, input addr_t addr);
        ctrl_frame_t            f;
        logic [FRAME_WIDTH-1:0] bits;
        int                     i;
        f.start = start;
        f.sid   = sid;
        f.write = wr;
        f.burst = burst;
        f.addr  = addr;
        bits    = f;
        for (i = FRAME_WIDTH - 1; i >= 0; i--) begin
            control = bits[i];
            next_cycle();
        end
        control = 1'b0;
    endtask

    task automatic write_word(input data_t word, input bit gaps, input bit is_last);
        int n;
        int i;
        n = 0;
        while (!ready && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (!ready) begin
            report_timeout("ready before write data");
            return;
        end
        last = is_last;
        i    = DATA_WIDTH - 1;
        while (i >= 0) begin
            if (gaps && $urandom_range(3) == 0) begin
                // stall cycle, wD toggles but must be ignored
                valid = 1'b0;
                wD    = ~wD;
            end else begin
                valid = 1'b1;
                wD    = word[i];
                i--;
            end
            next_cycle();
        end
        valid = 1'b0;
        wD    = 1'b0;
        // store cycle, no bit may be offered here
        next_cycle();
        last = 1'b0;
    endtask

    // waits for a rising edge on ready, then samples 32 rD bits
    task automatic read_word(output data_t word, output int lat, input bit is_last);
        int n;
        int i;
        bit seen_low;
        bit ready_held;
        n          = 0;
        seen_low   = 1'b0;
        ready_held = 1'b1;
        word       = '0;
        lat        = 0;
        while (!(ready && seen_low)) begin
            if (!ready) begin
                seen_low = 1'b1;
            end
            if (n == TIMEOUT) begin
                report_timeout("a rising edge on ready before read data");
                return;
            end
            next_cycle();
            n++;
        end
        lat  = n;
        last = is_last;
        for (i = DATA_WIDTH - 1; i >= 0; i--) begin
            word[i] = rD;
            if (!ready) begin
                ready_held = 1'b0;
            end
            if (i > 0) begin
                next_cycle();
            end
        end
        last = 1'b0;
        check_true(ready_held, "ready went low while a read word was on rD");
    endtask

    task automatic read_single(input addr_t addr, output data_t word, output int lat);
        send_frame(START_PATTERN, SLAVE_ID, 1'b0, 1'b0, addr);
        read_word(word, lat, 1'b0);
        next_cycle();
    endtask

    task automatic write_single(input addr_t addr, input data_t word, input bit gaps);
        send_frame(START_PATTERN, SLAVE_ID, 1'b1, 1'b0, addr);
        write_word(word, gaps, 1'b0);
        ref_mem[int'(addr)] = word;
    endtask

    task automatic test_reset_state();
        int e0;
        e0 = errors;
        check_value("ready", 32'(ready), 32'h1);
        check_value("rD", 32'(rD), 32'h0);
        next_cycle();
        log_test_end("reset_state", e0);
    endtask

    task automatic test_single_write_read();
        addr_t addrs [6];
        data_t got;
        int    lat;
        int    e0;
        int    k;
        e0 = errors;
        for (k = 0; k < 6; k++) begin
            addrs[k] = addr_t'($urandom_range(MEM_DEPTH - 1));
            write_single(addrs[k], $urandom(), k[0]);
        end
        for (k = 0; k < 6; k++) begin
            read_single(addrs[k], got, lat);
            check_value("rD word", got, ref_mem[int'(addrs[k])]);
            // lat counts from the cycle after frame bit 0
            check_true(lat + 1 == ACCESS_DELAY + 3,
                       $sformatf("first rD bit came %0d cycles after frame bit 0, not %0d",
                                 lat + 1, ACCESS_DELAY + 3));
        end
        log_test_end("single_write_read", e0);
    endtask

    task automatic test_burst_write();
        data_t got;
        data_t d;
        int    lat;
        int    base;
        int    e0;
        int    j;
        e0   = errors;
        base = $urandom_range(MEM_DEPTH - 7);
        // guard word right after the burst
        write_single(addr_t'(base + 5), $urandom(), 1'b0);
        send_frame(START_PATTERN, SLAVE_ID, 1'b1, 1'b1, addr_t'(base));
        for (j = 0; j < 5; j++) begin
            d = $urandom();
            write_word(d, j[0], j == 4);
            ref_mem[base + j] = d;
        end
        for (j = 0; j <= 5; j++) begin
            read_single(addr_t'(base + j), got, lat);
            check_value("rD word", got, ref_mem[base + j]);
        end
        log_test_end("burst_write", e0);
    endtask

    task automatic test_burst_read();
        data_t got;
        int    lat;
        int    base;
        int    e0;
        int    j;
        bit    stayed_idle;
        e0   = errors;
        base = $urandom_range(MEM_DEPTH - 5);
        for (j = 0; j < 4; j++) begin
            write_single(addr_t'(base + j), $urandom(), 1'b1);
        end
        send_frame(START_PATTERN, SLAVE_ID, 1'b0, 1'b1, addr_t'(base));
        for (j = 0; j < 4; j++) begin
            read_word(got, lat, j == 3);
            check_value("rD word", got, ref_mem[base + j]);
        end
        stayed_idle = 1'b1;
        for (j = 0; j < 2 * (ACCESS_DELAY + 3); j++) begin
            next_cycle();
            if (!ready || rD) begin
                stayed_idle = 1'b0;
            end
        end
        check_true(stayed_idle, "the burst read went on after the final word");
        log_test_end("burst_read", e0);
    endtask

    task automatic test_wrong_frame();
        addr_t addr;
        data_t got;
        int    lat;
        int    e0;
        e0   = errors;
        addr = addr_t'($urandom_range(MEM_DEPTH - 1));
        write_single(addr, $urandom(), 1'b0);
        // wrong slave ID, then a bad start pattern
        send_frame(START_PATTERN, SLAVE_ID ^ 2'b11, 1'b1, 1'b0, addr);
        write_word(~ref_mem[int'(addr)], 1'b0, 1'b0);
        send_frame(3'b101, SLAVE_ID, 1'b1, 1'b0, addr);
        write_word(~ref_mem[int'(addr)], 1'b0, 1'b0);
        read_single(addr, got, lat);
        check_value("rD word", got, ref_mem[int'(addr)]);
        log_test_end("wrong_frame", e0);
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        timed_out = 1'b0;
        rstN      = 1'b0;
        control   = 1'b0;
        wD        = 1'b0;
        valid     = 1'b0;
        last      = 1'b0;
        void'($urandom(SEED));
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rstN = 1'b1;

        test_reset_state();
        if (!timed_out) begin
            test_single_write_read();
        end
        if (!timed_out) begin
            test_burst_write();
        end
        if (!timed_out) begin
            test_burst_read();
        end
        if (!timed_out) begin
            test_wrong_frame();
        end

        $display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
